/* verilog/afifo_pkg.sv */
package afifo_pkg;

   // word and pointer widths
   localparam int data_w = 8;
   localparam int addr_w = 4;

   // array entries, one per pointer code
   localparam int fifo_depth = 1 << addr_w;

   // one entry stays unused so the gray sequence never laps
   localparam int full_level = fifo_depth - 1;

   // one data word
   typedef logic [data_w-1:0] data_t;

   // gray coded pointer, also the array address
   typedef logic [addr_w-1:0] ptr_t;

   // binary occupancy count
   typedef logic [addr_w-1:0] level_t;

   // gray to binary, msb first
   function automatic level_t gray2bin(input ptr_t gray);
      level_t bin;
      bin[addr_w-1] = gray[addr_w-1];
      for (int i = addr_w - 2; i >= 0; i--) begin
         bin[i] = gray[i] ^ bin[i + 1];
      end
      return bin;
   endfunction

endpackage

/* verilog/fifo_mem_if.sv */
`timescale 1ns/1ns

interface fifo_mem_if import afifo_pkg::*; ();

   // write port, wclk domain
   logic  w_en;
   ptr_t  w_addr;
   data_t w_data;

   // read port, rclk domain
   logic  r_en;
   ptr_t  r_addr;
   data_t r_data;

   // write side control drives the write port
   modport wr (
      output w_en,
      output w_addr,
      output w_data
   );

   // read side control drives the read address
   modport rd (
      output r_en,
      output r_addr
   );

   // the array
   modport mem (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

/* verilog/gray_counter.sv */
`timescale 1ns/1ns

module gray_counter import afifo_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic en,
   output ptr_t gray
);

   // binary count runs one step ahead of the gray register
   logic [addr_w-1:0] bin_count;
   ptr_t              gray_reg;
   ptr_t              gray_next;

   // gray code of the count ahead
   always_comb begin
      gray_next = bin_count ^ (bin_count >> 1);
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin_count <= addr_w'(1);
         gray_reg  <= '0;
      end
      else if (en) begin
         bin_count <= bin_count + 1'b1;
         gray_reg  <= gray_next;
      end
   end

   // registered, so only one bit flips per step
   assign gray = gray_reg;

endmodule

/* verilog/fifo_ram.sv */
`timescale 1ns/1ns

module fifo_ram import afifo_pkg::*; (
   input logic     wclk,
   input logic     rclk,
   input logic     rst,
   fifo_mem_if.mem mem
);

   // storage, one word per gray code
   data_t storage [fifo_depth];

   // read word register
   data_t rd_word;

   // write port on wclk
   always_ff @(posedge wclk) begin
      if (mem.w_en) begin
         storage[mem.w_addr] <= mem.w_data;
      end
   end

   // read port on rclk, holds between reads
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         rd_word <= '0;
      end
      else if (mem.r_en) begin
         rd_word <= storage[mem.r_addr];
      end
   end

   assign mem.r_data = rd_word;

endmodule

/* verilog/fifo_wr_ctrl.sv */
`timescale 1ns/1ns

module fifo_wr_ctrl import afifo_pkg::*; (
   input  logic   wclk,
   input  logic   rst,
   input  logic   write_en,
   input  data_t  data_in,
   input  ptr_t   rd_ptr,
   output ptr_t   wr_ptr,
   output logic   full,
   output level_t level_w,
   fifo_mem_if.wr mem
);

   // read pointer brought into wclk
   ptr_t rd_ptr_meta;
   ptr_t rd_ptr_sync;

   // own pointer from the counter
   ptr_t wr_ptr_gray;

   // write that actually goes in
   logic wr_accept;

   // level from binary pointers
   level_t wr_bin;
   level_t rd_bin;
   level_t level;

   // two stage synchronizer
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rd_ptr_meta <= '0;
         rd_ptr_sync <= '0;
      end
      else begin
         rd_ptr_meta <= rd_ptr;
         rd_ptr_sync <= rd_ptr_meta;
      end
   end

   // reads show up late here, so the level only overestimates
   always_comb begin
      wr_bin = gray2bin(wr_ptr_gray);
      rd_bin = gray2bin(rd_ptr_sync);
      level  = wr_bin - rd_bin;
   end

   assign full      = (level == level_t'(full_level));
   assign level_w   = level;

   // writes while full are dropped
   assign wr_accept = write_en & ~full;

   gray_counter u_wr_cnt (
      .clk  (wclk),
      .rst  (rst),
      .en   (wr_accept),
      .gray (wr_ptr_gray)
   );

   // array write port
   assign mem.w_en   = wr_accept;
   assign mem.w_addr = wr_ptr_gray;
   assign mem.w_data = data_in;

   // pointer to the read side
   assign wr_ptr     = wr_ptr_gray;

endmodule

/* verilog/fifo_rd_ctrl.sv */
`timescale 1ns/1ns

module fifo_rd_ctrl import afifo_pkg::*; (
   input  logic   rclk,
   input  logic   rst,
   input  logic   read_en,
   input  ptr_t   wr_ptr,
   output ptr_t   rd_ptr,
   output logic   empty,
   output level_t level_r,
   fifo_mem_if.rd mem
);

   // write pointer brought into rclk
   ptr_t wr_ptr_meta;
   ptr_t wr_ptr_sync;

   // own pointer from the counter
   ptr_t rd_ptr_gray;

   // read that actually happens
   logic rd_accept;

   // level from binary pointers
   level_t wr_bin;
   level_t rd_bin;
   level_t level;

   // two stage synchronizer
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         wr_ptr_meta <= '0;
         wr_ptr_sync <= '0;
      end
      else begin
         wr_ptr_meta <= wr_ptr;
         wr_ptr_sync <= wr_ptr_meta;
      end
   end

   // writes show up late here, so the level only underestimates
   always_comb begin
      wr_bin = gray2bin(wr_ptr_sync);
      rd_bin = gray2bin(rd_ptr_gray);
      level  = wr_bin - rd_bin;
   end

   assign empty     = (level == '0);
   assign level_r   = level;

   // reads while empty are dropped
   assign rd_accept = read_en & ~empty;

   gray_counter u_rd_cnt (
      .clk  (rclk),
      .rst  (rst),
      .en   (rd_accept),
      .gray (rd_ptr_gray)
   );

   // array read port
   assign mem.r_en   = rd_accept;
   assign mem.r_addr = rd_ptr_gray;

   // pointer to the write side
   assign rd_ptr     = rd_ptr_gray;

endmodule

/* verilog/async_fifo.sv */
`timescale 1ns/1ns

module async_fifo import afifo_pkg::*; (
   input  logic   wclk,
   input  logic   rclk,
   input  logic   rst,

   // write side
   input  logic   write_en,
   input  data_t  data_in,
   output logic   full,
   output level_t level_w,

   // read side
   input  logic   read_en,
   output data_t  data_out,
   output logic   empty,
   output level_t level_r
);

   // gray pointers crossing between the domains
   ptr_t wr_ptr;
   ptr_t rd_ptr;

   // array ports
   fifo_mem_if mem_bus ();

   fifo_wr_ctrl u_wr_ctrl (
      .wclk     (wclk),
      .rst      (rst),
      .write_en (write_en),
      .data_in  (data_in),
      .rd_ptr   (rd_ptr),
      .wr_ptr   (wr_ptr),
      .full     (full),
      .level_w  (level_w),
      .mem      (mem_bus.wr)
   );

   fifo_rd_ctrl u_rd_ctrl (
      .rclk    (rclk),
      .rst     (rst),
      .read_en (read_en),
      .wr_ptr  (wr_ptr),
      .rd_ptr  (rd_ptr),
      .empty   (empty),
      .level_r (level_r),
      .mem     (mem_bus.rd)
   );

   fifo_ram u_ram (
      .wclk (wclk),
      .rclk (rclk),
      .rst  (rst),
      .mem  (mem_bus.mem)
   );

   // read word comes straight from the array register
   assign data_out = mem_bus.r_data;

endmodule

/* test/async_fifo_props.sv */
`timescale 1ns/1ns

module async_fifo_props import afifo_pkg::*; (
   input logic clk,
   input logic rst,
   input logic en,
   input logic flag,
   input logic flag_rst,
   input ptr_t ptr
);

   // failures seen so far
   int fail_count = 0;

   // a request made against full or empty leaves the pointer alone
   en_vs_flag: assert property (@(posedge clk) disable iff (rst)
                                (en && flag) |=> $stable(ptr))
      else begin
         $error("pointer moved on a request made while its flag was set");
         fail_count++;
      end

   // full low, empty high while in reset
   flag_in_reset: assert property (@(posedge clk) rst |-> (flag == flag_rst))
      else begin
         $error("flag has the wrong value during reset");
         fail_count++;
      end

   // one code step per clock at most
   gray_step: assert property (@(posedge clk) disable iff (rst)
                               $countones(ptr ^ $past(ptr)) <= 1)
      else begin
         $error("gray pointer changed in more than one bit");
         fail_count++;
      end

endmodule

bind fifo_wr_ctrl async_fifo_props wr_props (
   .clk      (wclk),
   .rst      (rst),
   .en       (write_en),
   .flag     (full),
   .flag_rst (1'b0),
   .ptr      (wr_ptr_gray)
);

bind fifo_rd_ctrl async_fifo_props rd_props (
   .clk      (rclk),
   .rst      (rst),
   .en       (read_en),
   .flag     (empty),
   .flag_rst (1'b1),
   .ptr      (rd_ptr_gray)
);

/* test/async_fifo_tb.sv */
`timescale 1ns/1ns

module async_fifo_tb import afifo_pkg::*; ();

   localparam int tdata_len    = 228;
   localparam int wait_limit   = 50;
   localparam int stream_limit = 5000;

   logic   wclk;
   logic   rclk;
   logic   rst;
   logic   write_en;
   data_t  data_in;
   logic   full;
   level_t level_w;
   logic   read_en;
   data_t  data_out;
   logic   empty;
   level_t level_r;

   // data file, a count then its words for each section
   data_t tdata [tdata_len];

   // reference model of the words held in the fifo
   data_t model_q [$];

   int    errors;
   int    bound_errors;
   int    tests_ok;
   int    tests_bad;
   int    mark;
   int    seed;
   int    wr_seed;
   int    rd_seed;
   int    fill_n;
   int    extra_base;
   int    extra_n;
   int    stream_base;
   int    stream_n;
   int    nread;
   int    n;
   int    assert_fails;
   logic  bound_on;
   logic  wr_done;
   logic  done;
   data_t last_out;

   async_fifo uut (
      .wclk     (wclk),
      .rclk     (rclk),
      .rst      (rst),
      .write_en (write_en),
      .data_in  (data_in),
      .full     (full),
      .level_w  (level_w),
      .read_en  (read_en),
      .data_out (data_out),
      .empty    (empty),
      .level_r  (level_r)
   );

   initial begin
      wclk = 1'b0;
      forever #2 wclk = ~wclk;
   end

   initial begin
      rclk = 1'b0;
      forever #3 rclk = ~rclk;
   end

   // write side of the model, judged at the edge
   always @(posedge wclk) begin
      if (!rst) begin
         if (bound_on && int'(level_w) < model_q.size()) begin
            $display("Error at %0t ns: level_w %0d below occupancy %0d", $time, level_w,
                     model_q.size());
            bound_errors++;
         end
         if (write_en && !full) begin
            model_q.push_back(data_in);
         end
      end
   end

   // read side of the model, data_out checked half a cycle later
   always @(posedge rclk) begin
      data_t expected;
      if (!rst) begin
         if (bound_on && int'(level_r) > model_q.size()) begin
            $display("Error at %0t ns: level_r %0d above occupancy %0d", $time, level_r,
                     model_q.size());
            bound_errors++;
         end
         expected = last_out;
         if (read_en && !empty) begin
            if (model_q.size() == 0) begin
               $display("Error at %0t ns: read accepted with the model empty", $time);
               errors++;
            end
            else begin
               expected = model_q.pop_front();
            end
         end
         @(negedge rclk);
         if (data_out !== expected) begin
            $display("Error at %0t ns: data_out %h, expected %h", $time, data_out, expected);
            errors++;
         end
         last_out = expected;
      end
   end

   task automatic write_word(input data_t word);
      int   cnt;
      logic took;
      cnt      = 0;
      took     = 1'b0;
      write_en = 1'b1;
      data_in  = word;
      while (!took && cnt < wait_limit) begin
         @(posedge wclk);
         took = !full;
         cnt++;
         #1;
      end
      write_en = 1'b0;
      if (!took) begin
         $display("Timeout: write of %h not accepted within %0d wclk cycles", word, wait_limit);
         errors++;
      end
   endtask

   task automatic wait_read_level(input level_t target, input int limit);
      int   cnt;
      logic hit;
      cnt = 0;
      hit = 1'b0;
      while (!hit && cnt < limit) begin
         @(posedge rclk);
         hit = (level_r == target);
         cnt++;
      end
      if (!hit) begin
         $display("Timeout: level_r did not reach %0d within %0d rclk cycles", target, limit);
         errors++;
      end
   endtask

   task automatic stream_writes();
      int idx;
      int cnt;
      int rnd;
      idx = 0;
      cnt = 0;
      @(posedge wclk);
      #1;
      data_in  = tdata[stream_base + 1];
      rnd      = $random(wr_seed);
      write_en = rnd[0];
      while (idx < stream_n && cnt < stream_limit) begin
         @(posedge wclk);
         cnt++;
         if (write_en && !full) begin
            idx++;
         end
         #1;
         rnd      = $random(wr_seed);
         write_en = rnd[0] && (idx < stream_n);
         if (idx < stream_n) begin
            data_in = tdata[stream_base + 1 + idx];
         end
      end
      write_en = 1'b0;
      wr_done  = 1'b1;
      if (idx < stream_n) begin
         $display("Timeout: only %0d of %0d stream words written", idx, stream_n);
         errors++;
      end
   endtask

   task automatic stream_reads();
      int cnt;
      int rnd;
      cnt = 0;
      while (!(wr_done && model_q.size() == 0) && cnt < stream_limit) begin
         @(posedge rclk);
         cnt++;
         #1;
         rnd     = $random(rd_seed);
         read_en = rnd[0];
      end
      read_en = 1'b0;
      if (!(wr_done && model_q.size() == 0)) begin
         $display("Timeout: stream reads did not drain the fifo");
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int errs);
      if (errs == 0) begin
         tests_ok++;
         $display("Test %0d %s: ok", num, name);
      end
      else begin
         tests_bad++;
         $display("Test %0d %s: %0d errors", num, name, errs);
      end
   endtask

   initial begin
      rst      = 1'b1;
      write_en = 1'b0;
      read_en  = 1'b0;
      data_in  = '0;
      last_out = '0;
      bound_on = 1'b0;
      wr_done  = 1'b0;
      errors       = 0;
      bound_errors = 0;
      tests_ok     = 0;
      tests_bad    = 0;
      seed    = 21389;
      wr_seed = seed;
      rd_seed = seed + 1;
      $readmemh("test/async_fifo_testdata.txt", tdata);
      fill_n      = int'(tdata[0]);
      extra_base  = fill_n + 1;
      extra_n     = int'(tdata[extra_base]);
      stream_base = extra_base + extra_n + 1;
      stream_n    = int'(tdata[stream_base]);
      repeat (16) @(posedge wclk);
      #1;
      rst = 1'b0;

      mark = errors;
      if (empty !== 1'b1 || full !== 1'b0 || level_w !== '0 || level_r !== '0 ||
          data_out !== '0) begin
         $display("Error at %0t ns: after reset empty %b full %b levels %0d %0d data %h",
                  $time, empty, full, level_w, level_r, data_out);
         errors++;
      end
      report_test(1, "reset state", errors - mark);

      mark = errors;
      for (int i = 1; i <= fill_n; i++) begin
         write_word(tdata[i]);
      end
      if (full !== 1'b1 || level_w !== level_t'(full_level)) begin
         $display("Error at %0t ns: after fill full %b level_w %0d", $time, full, level_w);
         errors++;
      end
      // these all land on a full fifo
      for (int i = 1; i <= extra_n; i++) begin
         write_en = 1'b1;
         data_in  = tdata[extra_base + i];
         @(posedge wclk);
         #1;
      end
      write_en = 1'b0;
      if (level_w !== level_t'(full_level)) begin
         $display("Error at %0t ns: level_w %0d after writes while full", $time, level_w);
         errors++;
      end
      n    = 0;
      done = 1'b0;
      while (!done && n < 10) begin
         @(posedge rclk);
         done = !empty;
         n++;
      end
      if (!done) begin
         $display("Timeout: empty still high 10 rclk cycles after the fill");
         errors++;
      end
      wait_read_level(level_t'(full_level), 10);
      report_test(2, "fill to full", errors - mark);

      mark  = errors;
      nread = 0;
      n     = 0;
      done  = 1'b0;
      @(posedge rclk);
      #1;
      read_en = 1'b1;
      while (!done && n < wait_limit) begin
         @(posedge rclk);
         n++;
         if (empty) begin
            done = 1'b1;
         end
         else begin
            nread++;
         end
         #1;
         if (!done && data_out !== tdata[nread]) begin
            $display("Error at %0t ns: read %0d gave %h, expected %h", $time, nread,
                     data_out, tdata[nread]);
            errors++;
         end
      end
      if (!done) begin
         $display("Timeout: fifo not empty after %0d rclk cycles of reads", wait_limit);
         errors++;
      end
      if (nread != fill_n) begin
         $display("Error at %0t ns: %0d reads before empty, expected %0d", $time, nread, fill_n);
         errors++;
      end
      repeat (4) @(posedge rclk);
      #1;
      read_en = 1'b0;
      if (data_out !== tdata[fill_n]) begin
         $display("Error at %0t ns: data_out %h moved while empty", $time, data_out);
         errors++;
      end
      report_test(3, "drain in order", errors - mark);

      mark     = errors;
      bound_on = 1'b1;
      fork
         stream_writes();
         stream_reads();
      join
      bound_on = 1'b0;
      // the write side learns of the last reads late
      n    = 0;
      done = 1'b0;
      while (!done && n < wait_limit) begin
         @(posedge wclk);
         done = (level_w == '0);
         n++;
      end
      #1;
      if (!done) begin
         $display("Timeout: level_w did not return to zero after streaming");
         errors++;
      end
      if (empty !== 1'b1 || model_q.size() != 0) begin
         $display("Error at %0t ns: after streaming empty %b, model holds %0d", $time, empty,
                  model_q.size());
         errors++;
      end
      report_test(4, "concurrent streaming", errors - mark);
      report_test(5, "level bounds", bound_errors);

      assert_fails = uut.u_wr_ctrl.wr_props.fail_count + uut.u_rd_ctrl.rd_props.fail_count;
      if (assert_fails != 0) begin
         $display("Assertions failed %0d times during the run", assert_fails);
      end
      $display("Tests: %0d ok, %0d with errors", tests_ok, tests_bad);
      if (tests_bad == 0 && assert_fails == 0) begin
         $display("Regression passed");
      end
      else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* test/async_fifo_testdata.txt */
// one hex byte per token, read in order
// each section is a word count and then its words in write order
// test 2 fill, also the read order expected by test 3
0f
11 22 33 44 55 66 77 88
99 aa bb cc dd ee ff
// test 2 writes while full, never read back
0a
e1 e2 e3 e4 e5 e6 e7 e8 e9 ea
// test 4 streaming, read back in this order
c8
00 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0
01 11 21 31 41 51 61 71 81 91 a1 b1 c1 d1 e1 f1
02 12 22 32 42 52 62 72 82 92 a2 b2 c2 d2 e2 f2
03 13 23 33 43 53 63 73 83 93 a3 b3 c3 d3 e3 f3
04 14 24 34 44 54 64 74 84 94 a4 b4 c4 d4 e4 f4
05 15 25 35 45 55 65 75 85 95 a5 b5 c5 d5 e5 f5
06 16 26 36 46 56 66 76 86 96 a6 b6 c6 d6 e6 f6
07 17 27 37 47 57 67 77 87 97 a7 b7 c7 d7 e7 f7
08 18 28 38 48 58 68 78 88 98 a8 b8 c8 d8 e8 f8
09 19 29 39 49 59 69 79 89 99 a9 b9 c9 d9 e9 f9
0a 1a 2a 3a 4a 5a 6a 7a 8a 9a aa ba ca da ea fa
0b 1b 2b 3b 4b 5b 6b 7b 8b 9b ab bb cb db eb fb
0c 1c 2c 3c 4c 5c 6c 7c

/* tb.f */
verilog/afifo_pkg.sv
verilog/fifo_mem_if.sv
verilog/gray_counter.sv
verilog/fifo_ram.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/async_fifo.sv
test/async_fifo_props.sv
test/async_fifo_tb.sv

/* run.sh */
#!/bin/sh
# build and run the dual-clock FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module async_fifo_tb -f tb.f -o async_fifo_sim

out=$(./obj_dir/async_fifo_sim +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1
